/* tb.f */
rtl/neoVideoPkg.sv
rtl/pixelClockGen.sv
rtl/sysLatch.sv
rtl/paletteRam.sv
rtl/colorConvert.sv
rtl/neoVideoOut.sv
tests/tbNeoVideoOut.sv

/* tests/tbNeoVideoOut.sv */
/*
  Directed testbench for the palette unit. Inputs change on rising edges and outputs
  are sampled on falling edges. Palette words are written before any colour is checked.
*/
`timescale 1ns/1ps

module tbNeoVideoOut;

	localparam int PIXEL_DIV = 8;
	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_ENTRIES = 8;
	localparam int NUM_COLORS = 16;
	// Run time budget of tests times worst-case cycles per test
	localparam int NUM_TESTS = 5;
	localparam int WORST_CYCLES = 700;

	logic CLK_48M;
	logic nRESET;
	neoVideoPkg::cpuBus_t cpu;
	logic [neoVideoPkg::PAL_INDEX_W-1:0] palIndex;
	neoVideoPkg::rgb_t color;
	logic pixelEnable;
	logic [15:0] cpuRdata;

	int errors;
	int checks;
	int unsigned seed;

	neoVideoOut #(
		.PIXEL_DIV(PIXEL_DIV)
	) DUT (
		.CLK_48M(CLK_48M),
		.nRESET(nRESET),
		.cpu(cpu),
		.palIndex(palIndex),
		.color(color),
		.pixelEnable(pixelEnable),
		.cpuRdata(cpuRdata)
	);

	initial begin
		CLK_48M = 1'b0;
		forever #(CLK_PERIOD / 2) CLK_48M = ~CLK_48M;
	end

	// Watchdog
	initial begin
		#(NUM_TESTS * WORST_CYCLES * CLK_PERIOD * 2);
		$display("Timeout: the tests did not finish in the expected time");
		$display("FAIL: see errors above");
		$finish;
	end

	// ============================================================
	// Compare tasks
	// ============================================================

	task automatic checkRgb(input string name, input neoVideoPkg::rgb_t actual,
		input neoVideoPkg::rgb_t expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error: %s = %h, expected %h", name, actual, expected);
		end
	endtask

	task automatic checkWord(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error: %s = %h, expected %h", name, actual, expected);
		end
	endtask

	task automatic checkBit(input string name, input logic actual, input logic expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error: %s = %h, expected %h", name, actual, expected);
		end
	endtask

	// ============================================================
	// Reference model
	// ============================================================

	// Level 0..63 from nibble, LSB and repeated nibble MSB less the dark bit
	function automatic logic [7:0] modelChannel(input logic [3:0] nibble, input logic lsb,
		input logic dark, input logic shadowOn);
		int level;
		int value;
		level = int'(nibble) * 4 + int'(lsb) * 2 + int'(nibble[3]) - int'(dark);
		if (level < 0) begin
			value = 0;
		end else begin
			// Six level bits with level bits 4 and 3 filling the bottom
			value = (level % 64) * 4 + (level / 8) % 4;
		end
		if (shadowOn) begin
			value = value / 2;
		end
		return 8'(value);
	endfunction

	function automatic neoVideoPkg::rgb_t modelColor(input logic [15:0] word,
		input logic shadowOn);
		neoVideoPkg::paletteWord_t w;
		neoVideoPkg::rgb_t result;
		w = word;
		result.red = modelChannel(w.red, w.redLsb, w.dark, shadowOn);
		result.green = modelChannel(w.green, w.greenLsb, w.dark, shadowOn);
		result.blue = modelChannel(w.blue, w.blueLsb, w.dark, shadowOn);
		return result;
	endfunction

	// ============================================================
	// Bus and timing helpers
	// ============================================================

	// One-cycle strobe with the bus back to idle on the next edge
	task automatic driveBus(input neoVideoPkg::cpuBus_t bus);
		@(posedge CLK_48M);
		cpu <= bus;
		@(posedge CLK_48M);
		cpu <= '0;
	endtask

	task automatic writePalette(input logic [11:0] addr, input logic [15:0] data);
		neoVideoPkg::cpuBus_t bus;
		bus = '0;
		bus.addr = addr;
		bus.wdata = data;
		bus.palWr = 1'b1;
		driveBus(bus);
	endtask

	// Read data is registered and sampled after the strobe edge
	task automatic readPalette(input logic [11:0] addr, output logic [15:0] data);
		neoVideoPkg::cpuBus_t bus;
		bus = '0;
		bus.addr = addr;
		bus.palRd = 1'b1;
		driveBus(bus);
		@(negedge CLK_48M);
		data = cpuRdata;
	endtask

	// addr[2:0] picks the latch and addr[3] carries the value
	task automatic writeLatch(input logic [2:0] sel, input logic value);
		neoVideoPkg::cpuBus_t bus;
		bus = '0;
		bus.addr[2:0] = sel;
		bus.addr[3] = value;
		bus.latchWr = 1'b1;
		driveBus(bus);
	endtask

	// Returns at the falling edge after the last strobe edge
	task automatic waitStrobes(input int count);
		int seen;
		int cycles;
		seen = 0;
		cycles = 0;
		while (seen < count && cycles < (count + 1) * PIXEL_DIV + 2) begin
			@(negedge CLK_48M);
			cycles++;
			if (pixelEnable === 1'b1) begin
				seen++;
				@(posedge CLK_48M);
			end
		end
		if (seen < count) begin
			errors++;
			$display("Pixel strobe missing: saw %0d of %0d within %0d cycles",
				seen, count, cycles);
		end
		@(negedge CLK_48M);
	endtask

	// Two strobes guarantee the index was steady before the loading one
	task automatic showIndex(input logic [11:0] addr);
		@(posedge CLK_48M);
		palIndex <= addr;
		waitStrobes(2);
	endtask

	// ============================================================
	// Tests
	// ============================================================

	task automatic checkResetAndStrobe();
		int edges;
		repeat (RESET_CYCLES) @(posedge CLK_48M);
		nRESET <= 1'b1;
		// Edge number counted from the release edge
		for (edges = 1; edges <= 4 * PIXEL_DIV; edges++) begin
			@(negedge CLK_48M);
			if (edges == 1) begin
				checkRgb("color", color, '0);
				checkWord("cpuRdata", cpuRdata, '0);
			end
			checkBit("pixelEnable", pixelEnable, (edges % PIXEL_DIV) == 0);
		end
	endtask

	task automatic checkBankedPalette();
		logic [11:0] addrs [NUM_ENTRIES];
		logic [15:0] bank0 [NUM_ENTRIES];
		logic [15:0] bank1 [NUM_ENTRIES];
		logic [15:0] data;
		// Top bits from the entry number keep the addresses distinct
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			addrs[i] = {4'(i), 8'($urandom())};
			bank0[i] = 16'($urandom());
			bank1[i] = 16'($urandom());
			if (bank1[i] == bank0[i]) begin
				bank1[i] = ~bank0[i];
			end
		end
		writeLatch(neoVideoPkg::LATCH_PALBANK, 1'b0);
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			writePalette(addrs[i], bank0[i]);
		end
		writeLatch(neoVideoPkg::LATCH_PALBANK, 1'b1);
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			writePalette(addrs[i], bank1[i]);
		end
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			readPalette(addrs[i], data);
			checkWord("cpuRdata", data, bank1[i]);
		end
		writeLatch(neoVideoPkg::LATCH_PALBANK, 1'b0);
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			readPalette(addrs[i], data);
			checkWord("cpuRdata", data, bank0[i]);
		end
	endtask

	task automatic checkConversion();
		logic [11:0] addr;
		logic [15:0] word;
		for (int i = 0; i < NUM_COLORS; i++) begin
			addr = 12'($urandom());
			word = 16'($urandom());
			writePalette(addr, word);
			showIndex(addr);
			checkRgb("color", color, modelColor(word, 1'b0));
		end
	endtask

	task automatic checkDarkClamp();
		// Dark alone goes below zero on every channel
		writePalette(12'h010, 16'h8000);
		showIndex(12'h010);
		checkRgb("color", color, 24'h000000);
		writePalette(12'h011, 16'hffff);
		showIndex(12'h011);
		checkRgb("color", color, modelColor(16'hffff, 1'b0));
	endtask

	task automatic checkShadowAndSelects();
		neoVideoPkg::rgb_t full;
		neoVideoPkg::rgb_t half;
		logic [15:0] wordA;
		logic [15:0] wordB;
		logic [15:0] data;
		// Forced nibble bits keep every channel level well above zero on both words
		wordA = 16'($urandom()) | 16'h0888;
		wordB = ~wordA | 16'h0444;
		// Shadow on and off with bank 0
		writePalette(12'h020, wordA);
		showIndex(12'h020);
		full = modelColor(wordA, 1'b0);
		checkRgb("color", color, full);
		half.red = full.red >> 1;
		half.green = full.green >> 1;
		half.blue = full.blue >> 1;
		writeLatch(neoVideoPkg::LATCH_SHADOW, 1'b1);
		waitStrobes(2);
		checkRgb("color", color, half);
		writeLatch(neoVideoPkg::LATCH_SHADOW, 1'b0);
		waitStrobes(2);
		checkRgb("color", color, full);
		// Shadow and bank 1 set while other selects try to clear them
		writeLatch(neoVideoPkg::LATCH_PALBANK, 1'b1);
		writePalette(12'h020, wordB);
		writeLatch(neoVideoPkg::LATCH_SHADOW, 1'b1);
		for (int sel = 1; sel < 7; sel++) begin
			writeLatch(3'(sel), 1'b0);
		end
		waitStrobes(2);
		checkRgb("color", color, modelColor(wordB, 1'b1));
		readPalette(12'h020, data);
		checkWord("cpuRdata", data, wordB);
		// Both cleared while other selects try to set them
		writeLatch(neoVideoPkg::LATCH_SHADOW, 1'b0);
		writeLatch(neoVideoPkg::LATCH_PALBANK, 1'b0);
		for (int sel = 1; sel < 7; sel++) begin
			writeLatch(3'(sel), 1'b1);
		end
		waitStrobes(2);
		checkRgb("color", color, full);
		readPalette(12'h020, data);
		checkWord("cpuRdata", data, wordA);
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial begin
		seed = 32'hb7486c55;
		void'($urandom(seed));
		errors = 0;
		checks = 0;
		nRESET <= 1'b0;
		cpu <= '0;
		palIndex <= '0;
		checkResetAndStrobe();
		checkBankedPalette();
		checkConversion();
		checkDarkClamp();
		checkShadowAndSelects();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* rtl/neoVideoOut.sv */
/*
  Standalone palette unit: latch, two-bank palette RAM and RGB conversion.
  Index must be steady two cycles before a pixel strobe to show after that strobe.
*/
`timescale 1ns/1ps

module neoVideoOut #(
	// CLK_48M cycles per pixel
	parameter int PIXEL_DIV = 8
) (
	input logic CLK_48M,
	input logic nRESET,
	input neoVideoPkg::cpuBus_t cpu,
	input logic [neoVideoPkg::PAL_INDEX_W-1:0] palIndex,
	output neoVideoPkg::rgb_t color,
	output logic pixelEnable,
	output logic [neoVideoPkg::PAL_WORD_W-1:0] cpuRdata
);

	// Latch outputs
	logic shadow;
	logic palBank;

	// Pixel timing
	logic pixelStrobe;

	// Palette entry for the current index, one cycle late
	neoVideoPkg::paletteWord_t videoWord;

	// ============================================================
	// Timing and control
	// ============================================================

	pixelClockGen #(
		.PIXEL_DIV(PIXEL_DIV)
	) pixelClock (
		.CLK_48M(CLK_48M),
		.nRESET(nRESET),
		.pixelStrobe(pixelStrobe)
	);

	// Strobe goes out as the pixel clock enable
	assign pixelEnable = pixelStrobe;

	sysLatch latch (
		.CLK_48M(CLK_48M),
		.nRESET(nRESET),
		.cpu(cpu),
		.shadow(shadow),
		.palBank(palBank)
	);

	// ============================================================
	// Palette and colour path
	// ============================================================

	paletteRam palette (
		.CLK_48M(CLK_48M),
		.nRESET(nRESET),
		.cpu(cpu),
		.palBank(palBank),
		.palIndex(palIndex),
		.videoWord(videoWord),
		.cpuRdata(cpuRdata)
	);

	colorConvert converter (
		.CLK_48M(CLK_48M),
		.nRESET(nRESET),
		.pixelStrobe(pixelStrobe),
		.shadow(shadow),
		.videoWord(videoWord),
		.color(color)
	);

endmodule

/* rtl/colorConvert.sv */
/*
  Palette word to 24-bit RGB. Dark bit subtracts one step with a clamp at black,
  shadow halves each channel. Output only updates on the pixel strobe.
*/
`timescale 1ns/1ps

module colorConvert (
	input logic CLK_48M,
	input logic nRESET,
	input logic pixelStrobe,
	input logic shadow,
	input neoVideoPkg::paletteWord_t videoWord,
	output neoVideoPkg::rgb_t color
);

	// ============================================================
	// Channel expansion
	// ============================================================

	// Builds a 6-bit level from nibble and LSB, then widens to 8 bits
	function automatic logic [7:0] expandChannel(
		input logic [3:0] nibble,
		input logic lsb,
		input logic dark,
		input logic halve
	);
		logic [6:0] level;
		logic [7:0] full;
		// Extra top bit of the nibble acts as the reference darkening step
		level = {1'b0, nibble, lsb, nibble[3]} - {6'd0, dark};
		// Bit 6 set means the subtraction went below zero
		if (level[6]) begin
			full = 8'd0;
		end else begin
			// Replicate upper bits into the low end to reach full scale
			full = {level[5:0], level[4:3]};
		end
		if (halve) begin
			return {1'b0, full[7:1]};
		end
		return full;
	endfunction

	neoVideoPkg::rgb_t nextColor;

	always_comb begin
		nextColor.red = expandChannel(videoWord.red, videoWord.redLsb,
			videoWord.dark, shadow);
		nextColor.green = expandChannel(videoWord.green, videoWord.greenLsb,
			videoWord.dark, shadow);
		nextColor.blue = expandChannel(videoWord.blue, videoWord.blueLsb,
			videoWord.dark, shadow);
	end

	// ============================================================
	// Pixel output register
	// ============================================================

	// Loads the word present on the strobe edge
	always_ff @(posedge CLK_48M or negedge nRESET) begin
		if (!nRESET) begin
			color <= '0;
		end else if (pixelStrobe) begin
			color <= nextColor;
		end
	end

endmodule

/* rtl/paletteRam.sv */
/*
  Two-bank palette memory, indexed by {palBank, index}. Both ports see the current bank.
  Reads are registered; a read colliding with a write returns the old word.
*/
`timescale 1ns/1ps

module paletteRam (
	input logic CLK_48M,
	input logic nRESET,
	input neoVideoPkg::cpuBus_t cpu,
	input logic palBank,
	input logic [neoVideoPkg::PAL_INDEX_W-1:0] palIndex,
	output neoVideoPkg::paletteWord_t videoWord,
	output logic [neoVideoPkg::PAL_WORD_W-1:0] cpuRdata
);

	localparam int BANK_W = (neoVideoPkg::PAL_BANKS > 1) ? $clog2(neoVideoPkg::PAL_BANKS) : 1;
	localparam int ADDR_W = BANK_W + neoVideoPkg::PAL_INDEX_W;
	localparam int DEPTH = neoVideoPkg::PAL_BANKS << neoVideoPkg::PAL_INDEX_W;

	// Palette storage, CPU sees each entry as a plain word
	logic [neoVideoPkg::PAL_WORD_W-1:0] mem [DEPTH];

	logic [ADDR_W-1:0] cpuAddr;
	logic [ADDR_W-1:0] videoAddr;

	// Bank bit on top, index below
	assign cpuAddr = {BANK_W'(palBank), cpu.addr};
	assign videoAddr = {BANK_W'(palBank), palIndex};

	// ============================================================
	// CPU port
	// ============================================================

	// Single-cycle write
	always_ff @(posedge CLK_48M) begin
		if (cpu.palWr) begin
			mem[cpuAddr] <= cpu.wdata;
		end
	end

	// Read data holds until the next read strobe
	always_ff @(posedge CLK_48M or negedge nRESET) begin
		if (!nRESET) begin
			cpuRdata <= '0;
		end else if (cpu.palRd) begin
			cpuRdata <= mem[cpuAddr];
		end
	end

	// ============================================================
	// Video port
	// ============================================================

	// Read every cycle, one cycle after the index is presented
	always_ff @(posedge CLK_48M) begin
		videoWord <= neoVideoPkg::paletteWord_t'(mem[videoAddr]);
	end

endmodule

/* rtl/sysLatch.sv */
/*
  Address-encoded system latch. Only shadow and palette bank are kept;
  writes to the remaining select codes are ignored.
*/
`timescale 1ns/1ps

module sysLatch (
	input logic CLK_48M,
	input logic nRESET,
	input neoVideoPkg::cpuBus_t cpu,
	output logic shadow,
	output logic palBank
);

	// Select sits in the low address bits, value right above it
	localparam int VALUE_BIT = neoVideoPkg::LATCH_SEL_W;

	logic [neoVideoPkg::LATCH_SEL_W-1:0] latchSel;
	logic latchValue;

	assign latchSel = cpu.addr[neoVideoPkg::LATCH_SEL_W-1:0];
	assign latchValue = cpu.addr[VALUE_BIT];

	// ============================================================
	// Latch decode
	// ============================================================

	// New value is visible on the edge that samples the write strobe
	always_ff @(posedge CLK_48M or negedge nRESET) begin
		if (!nRESET) begin
			shadow <= 1'b0;
			palBank <= 1'b0;
		end else if (cpu.latchWr) begin
			case (latchSel)
				neoVideoPkg::LATCH_SHADOW: begin
					shadow <= latchValue;
				end
				neoVideoPkg::LATCH_PALBANK: begin
					palBank <= latchValue;
				end
				default: begin
					// Vector, card and SRAM enables lived here, not used by this unit
				end
			endcase
		end
	end

endmodule

/* rtl/pixelClockGen.sv */
/*
  Pixel strobe generator: one CLK_48M cycle high in every PIXEL_DIV cycles.
  PIXEL_DIV of 8 gives a 6 MHz pixel rate; first strobe comes at the end of a full period.
*/
`timescale 1ns/1ps

module pixelClockGen #(
	parameter int PIXEL_DIV = 8
) (
	input logic CLK_48M,
	input logic nRESET,
	output logic pixelStrobe
);

	// Counter must hold PIXEL_DIV-1, at least one bit wide
	localparam int CNT_W = (PIXEL_DIV > 1) ? $clog2(PIXEL_DIV) : 1;
	localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(PIXEL_DIV - 1);

	logic [CNT_W-1:0] count;

	// Free-running divider, wraps after the last value
	always_ff @(posedge CLK_48M or negedge nRESET) begin
		if (!nRESET) begin
			count <= '0;
		end else if (count == LAST_COUNT) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// High for the single cycle spent on the last count
	assign pixelStrobe = (count == LAST_COUNT);

endmodule

/* rtl/neoVideoPkg.sv */
/*
  Shared widths, latch select codes and bus/colour types for the palette unit.
  Palette words follow the original bit order: dark, RGB LSBs, then RGB nibbles.
*/

package neoVideoPkg;

	// ============================================================
	// Widths
	// ============================================================

	// Colour index within one bank
	localparam int PAL_INDEX_W = 12;
	// Number of palette banks, selected by the palette bank latch
	localparam int PAL_BANKS = 2;
	localparam int PAL_WORD_W = 16;
	localparam int LATCH_SEL_W = 3;

	// Latch select codes, taken from CPU address bits 2..0
	localparam logic [LATCH_SEL_W-1:0] LATCH_SHADOW = 3'd0;
	localparam logic [LATCH_SEL_W-1:0] LATCH_PALBANK = 3'd7;

	// ============================================================
	// Types
	// ============================================================

	// CPU side of the unit, single-cycle strobes with no acknowledge
	// For a latch write addr[2:0] is the select and addr[3] the new value
	typedef struct packed {
		logic [PAL_INDEX_W-1:0] addr;
		logic [PAL_WORD_W-1:0] wdata;
		logic palWr;
		logic palRd;
		logic latchWr;
	} cpuBus_t;

	// One palette entry as the video side decodes it
	typedef struct packed {
		logic dark;
		logic redLsb;
		logic greenLsb;
		logic blueLsb;
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} paletteWord_t;

	// Output pixel, 8 bits per channel
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

endpackage
